/* logic/mips_pkg.sv */
package mips_pkg;

    localparam int data_width      = 32;
    localparam int reg_addr_width  = 5;
    localparam int imem_addr_width = 6;
    localparam int dmem_addr_width = 6;

    // opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // r-type function codes
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sub = 3'd1;
    localparam logic [2:0] alu_and = 3'd2;
    localparam logic [2:0] alu_or  = 3'd3;
    localparam logic [2:0] alu_slt = 3'd4;

    // forwarding source into execute
    localparam logic [1:0] fwd_none = 2'd0;
    localparam logic [1:0] fwd_mem  = 2'd1;
    localparam logic [1:0] fwd_wb   = 2'd2;

    typedef struct packed {
        logic [5:0]                opcode;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [reg_addr_width-1:0] rd;
        logic [4:0]                shamt;
        logic [5:0]                funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]                opcode;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [15:0]               imm;
    } i_fields_t;

    // j target is rs, rt and imm of the i view taken together
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

endpackage

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
    import mips_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       imem_we,
    input  logic [imem_addr_width-1:0] imem_addr,
    input  logic [data_width-1:0]      imem_data,
    input  logic                       stall,
    input  logic                       branch_taken,
    input  logic [imem_addr_width-1:0] branch_target,
    output logic [imem_addr_width-1:0] if_pc,
    output instr_t                     if_instr
);

    logic [data_width-1:0]      imem [2**imem_addr_width];
    logic [imem_addr_width-1:0] pc;

    // loader port, only while the core is idle
    always_ff @(posedge clk) begin
        if (!run && imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    // fetch/decode register, all-zero word is a nop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_instr <= '0;
            if_pc    <= '0;
        end else if (!run || branch_taken) begin
            if_instr <= '0;
            if_pc    <= pc;
        end else if (!stall) begin
            if_instr <= imem[pc];
            if_pc    <= pc;
        end
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import mips_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [imem_addr_width-1:0] if_pc,
    input  instr_t                     if_instr,
    input  logic                       stall,
    input  logic                       bubble,
    input  logic [data_width-1:0]      mem_alu_result,
    input  logic [reg_addr_width-1:0]  mem_dest,
    input  logic                       mem_reg_write,
    input  logic                       wb_valid,
    input  logic [reg_addr_width-1:0]  wb_idx,
    input  logic [data_width-1:0]      wb_data,
    output logic                       branch_taken,
    output logic [imem_addr_width-1:0] branch_target,
    output logic [reg_addr_width-1:0]  id_rs,
    output logic [reg_addr_width-1:0]  id_rt,
    output logic                       id_is_branch,
    output logic                       id_uses_rt,
    output logic [2:0]                 ex_alu_op,
    output logic                       ex_reg_write,
    output logic                       ex_mem_read,
    output logic                       ex_mem_write,
    output logic [data_width-1:0]      ex_operand_a,
    output logic [data_width-1:0]      ex_operand_b,
    output logic [data_width-1:0]      ex_store_data,
    output logic [reg_addr_width-1:0]  ex_rs,
    output logic [reg_addr_width-1:0]  ex_rt,
    output logic [reg_addr_width-1:0]  ex_dest
);

    logic [data_width-1:0]     regs [2**reg_addr_width];
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     rs_data;
    logic [data_width-1:0]     rt_data;
    logic [data_width-1:0]     rs_cmp;
    logic [data_width-1:0]     rt_cmp;
    logic [data_width-1:0]     imm_ext;
    logic [25:0]               jump_field;
    logic [2:0]                alu_op;
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic                      use_imm;
    logic                      is_jump;
    logic                      take;

    assign rs         = if_instr.i.rs;
    assign rt         = if_instr.i.rt;
    assign imm_ext    = {{(data_width - 16){if_instr.i.imm[15]}}, if_instr.i.imm};
    assign jump_field = {if_instr.i.rs, if_instr.i.rt, if_instr.i.imm};

    always_comb begin
        alu_op       = alu_add;
        reg_write    = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        use_imm      = 1'b0;
        is_jump      = 1'b0;
        id_is_branch = 1'b0;
        id_uses_rt   = 1'b0;
        dest         = '0;
        case (if_instr.i.opcode)
            op_rtype: begin
                id_uses_rt = 1'b1;
                dest       = if_instr.r.rd;
                reg_write  = 1'b1;
                case (if_instr.r.funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    // nop and unsupported functions
                    default: reg_write = 1'b0;
                endcase
            end
            op_addi, op_lw: begin
                reg_write = 1'b1;
                mem_read  = (if_instr.i.opcode == op_lw);
                use_imm   = 1'b1;
                dest      = rt;
            end
            op_sw: begin
                mem_write  = 1'b1;
                use_imm    = 1'b1;
                id_uses_rt = 1'b1;
            end
            op_beq, op_bne: begin
                id_is_branch = 1'b1;
                id_uses_rt   = 1'b1;
            end
            op_j:    is_jump = 1'b1;
            default: ;
        endcase
    end

    // write-first register file, r0 reads as zero
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            regs[wb_idx] <= wb_data;
        end
    end

    assign rs_data = (rs == '0) ? '0 : (wb_valid && wb_idx == rs) ? wb_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 : (wb_valid && wb_idx == rt) ? wb_data : regs[rt];

    // branch operands with the memory-stage alu result forwarded
    assign rs_cmp = (mem_reg_write && mem_dest != '0 && mem_dest == rs) ? mem_alu_result : rs_data;
    assign rt_cmp = (mem_reg_write && mem_dest != '0 && mem_dest == rt) ? mem_alu_result : rt_data;

    always_comb begin
        take = is_jump;
        if (if_instr.i.opcode == op_beq) begin
            take = (rs_cmp == rt_cmp);
        end else if (if_instr.i.opcode == op_bne) begin
            take = (rs_cmp != rt_cmp);
        end
    end

    assign branch_taken  = take && !stall;
    assign branch_target = is_jump ? jump_field[imem_addr_width-1:0]
                                   : if_pc + 1'b1 + imm_ext[imem_addr_width-1:0];

    // j carries no source register
    assign id_rs = is_jump ? '0 : rs;
    assign id_rt = rt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else begin
            ex_reg_write <= reg_write && !bubble;
            ex_mem_read  <= mem_read && !bubble;
            ex_mem_write <= mem_write && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op     <= alu_op;
        ex_operand_a  <= rs_data;
        ex_operand_b  <= use_imm ? imm_ext : rt_data;
        ex_store_data <= rt_data;
        ex_rs         <= id_rs;
        ex_rt         <= id_uses_rt ? rt : '0;
        ex_dest       <= dest;
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
    import mips_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [2:0]                ex_alu_op,
    input  logic                      ex_reg_write,
    input  logic                      ex_mem_read,
    input  logic                      ex_mem_write,
    input  logic [data_width-1:0]     ex_operand_a,
    input  logic [data_width-1:0]     ex_operand_b,
    input  logic [data_width-1:0]     ex_store_data,
    input  logic [reg_addr_width-1:0] ex_dest,
    input  logic [1:0]                fwd_a_sel,
    input  logic [1:0]                fwd_b_sel,
    input  logic [data_width-1:0]     wb_data,
    output logic [data_width-1:0]     mem_alu_result,
    output logic [data_width-1:0]     mem_store_data,
    output logic [reg_addr_width-1:0] mem_dest,
    output logic                      mem_reg_write,
    output logic                      mem_mem_read,
    output logic                      mem_mem_write
);

    logic [data_width-1:0] op_a;
    logic [data_width-1:0] rt_val;
    logic [data_width-1:0] op_b;
    logic [data_width-1:0] result;

    function automatic logic [data_width-1:0] fwd_pick(
        input logic [1:0]            sel,
        input logic [data_width-1:0] reg_val,
        input logic [data_width-1:0] mem_val,
        input logic [data_width-1:0] wb_val
    );
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a   = fwd_pick(fwd_a_sel, ex_operand_a, mem_alu_result, wb_data);
    assign rt_val = fwd_pick(fwd_b_sel, ex_store_data, mem_alu_result, wb_data);
    // sw keeps its immediate as operand b, rt only feeds store data
    assign op_b   = (fwd_b_sel != fwd_none && !ex_mem_write) ? rt_val : ex_operand_b;

    always_comb begin
        case (ex_alu_op)
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_slt: result = data_width'($signed(op_a) < $signed(op_b));
            default: result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else begin
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result <= result;
        mem_store_data <= rt_val;
        mem_dest       <= ex_dest;
    end

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage
    import mips_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [data_width-1:0]     mem_alu_result,
    input  logic [data_width-1:0]     mem_store_data,
    input  logic [reg_addr_width-1:0] mem_dest,
    input  logic                      mem_reg_write,
    input  logic                      mem_mem_read,
    input  logic                      mem_mem_write,
    output logic                      wb_valid,
    output logic [reg_addr_width-1:0] wb_idx,
    output logic [data_width-1:0]     wb_data
);

    logic [data_width-1:0]      dmem [2**dmem_addr_width];
    logic [dmem_addr_width-1:0] word_idx;
    logic [data_width-1:0]      load_data;
    logic [data_width-1:0]      wb_alu;
    logic [data_width-1:0]      wb_load;
    logic                       wb_is_load;

    // byte address to word index
    assign word_idx  = mem_alu_result[dmem_addr_width+1:2];
    assign load_data = dmem[word_idx];

    always_ff @(posedge clk) begin
        if (mem_mem_write) begin
            dmem[word_idx] <= mem_store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid   <= 1'b0;
            wb_is_load <= 1'b0;
        end else begin
            wb_valid   <= mem_reg_write && (mem_dest != '0);
            wb_is_load <= mem_mem_read;
        end
    end

    always_ff @(posedge clk) begin
        wb_idx  <= mem_dest;
        wb_alu  <= mem_alu_result;
        wb_load <= load_data;
    end

    assign wb_data = wb_is_load ? wb_load : wb_alu;

endmodule

/* logic/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
    import mips_pkg::*;
(
    input  logic [reg_addr_width-1:0] id_rs,
    input  logic [reg_addr_width-1:0] id_rt,
    input  logic                      id_is_branch,
    input  logic                      id_uses_rt,
    input  logic [reg_addr_width-1:0] ex_rs,
    input  logic [reg_addr_width-1:0] ex_rt,
    input  logic [reg_addr_width-1:0] ex_dest,
    input  logic                      ex_reg_write,
    input  logic                      ex_mem_read,
    input  logic [reg_addr_width-1:0] mem_dest,
    input  logic                      mem_reg_write,
    input  logic                      mem_mem_read,
    input  logic [reg_addr_width-1:0] wb_idx,
    input  logic                      wb_valid,
    output logic [1:0]                fwd_a_sel,
    output logic [1:0]                fwd_b_sel,
    output logic                      stall,
    output logic                      bubble
);

    logic mem_fwd_ok;
    logic ex_hit;
    logic mem_hit;
    logic load_use;
    logic branch_wait;

    // a load in memory has no result yet
    assign mem_fwd_ok = mem_reg_write && !mem_mem_read && (mem_dest != '0);

    assign fwd_a_sel = (mem_fwd_ok && mem_dest == ex_rs) ? fwd_mem
                     : (wb_valid && ex_rs != '0 && wb_idx == ex_rs) ? fwd_wb : fwd_none;
    assign fwd_b_sel = (mem_fwd_ok && mem_dest == ex_rt) ? fwd_mem
                     : (wb_valid && ex_rt != '0 && wb_idx == ex_rt) ? fwd_wb : fwd_none;

    // decode sources matching a pending destination
    assign ex_hit  = (ex_dest != '0) && (ex_dest == id_rs || (id_uses_rt && ex_dest == id_rt));
    assign mem_hit = (mem_dest != '0) && (mem_dest == id_rs || (id_uses_rt && mem_dest == id_rt));

    assign load_use    = ex_mem_read && ex_hit;
    assign branch_wait = id_is_branch && ((ex_reg_write && ex_hit) ||
                                          (mem_mem_read && mem_reg_write && mem_hit));

    assign stall  = load_use || branch_wait;
    assign bubble = stall;

endmodule

/* logic/mips_pipeline.sv */
`timescale 1ns/1ps

module mips_pipeline
    import mips_pkg::*;
(
    input  logic                       clk_raw,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       imem_we,
    input  logic [imem_addr_width-1:0] imem_addr,
    input  logic [data_width-1:0]      imem_data,
    output logic                       wb_valid,
    output logic [reg_addr_width-1:0]  wb_idx,
    output logic [data_width-1:0]      wb_data
);

    // fetch to decode
    logic [imem_addr_width-1:0] if_pc;
    instr_t                     if_instr;
    logic                       branch_taken;
    logic [imem_addr_width-1:0] branch_target;

    // decode to hazard unit
    logic [reg_addr_width-1:0]  id_rs;
    logic [reg_addr_width-1:0]  id_rt;
    logic                       id_is_branch;
    logic                       id_uses_rt;

    // decode/execute register
    logic [2:0]                 ex_alu_op;
    logic                       ex_reg_write;
    logic                       ex_mem_read;
    logic                       ex_mem_write;
    logic [data_width-1:0]      ex_operand_a;
    logic [data_width-1:0]      ex_operand_b;
    logic [data_width-1:0]      ex_store_data;
    logic [reg_addr_width-1:0]  ex_rs;
    logic [reg_addr_width-1:0]  ex_rt;
    logic [reg_addr_width-1:0]  ex_dest;

    // execute/memory register
    logic [data_width-1:0]      mem_alu_result;
    logic [data_width-1:0]      mem_store_data;
    logic [reg_addr_width-1:0]  mem_dest;
    logic                       mem_reg_write;
    logic                       mem_mem_read;
    logic                       mem_mem_write;

    logic [1:0]                 fwd_a_sel;
    logic [1:0]                 fwd_b_sel;
    logic                       stall;
    logic                       bubble;

    fetch_stage u_fetch (.clk(clk_raw), .*);

    decode_stage u_decode (.clk(clk_raw), .*);

    execute_stage u_execute (.clk(clk_raw), .*);

    memory_stage u_memory (.clk(clk_raw), .*);

    hazard_unit u_hazard (.*);

endmodule

/* test/mips_pipeline_assertions.sv */
`timescale 1ns/1ps

module mips_pipeline_assertions
    import mips_pkg::*;
(
    input logic                      clk_raw,
    input logic                      rst_n,
    input logic                      run,
    input logic                      wb_valid,
    input logic [reg_addr_width-1:0] wb_idx
);

    // nothing retires while the core is idle
    assert property (@(posedge clk_raw) disable iff (!rst_n) !run |-> !wb_valid)
        else $error("write-back pulse while run is low");

    assert property (@(posedge clk_raw) disable iff (!rst_n) wb_valid |-> wb_idx != '0)
        else $error("write-back pulse for register 0");

    // first cycle out of reset
    assert property (@(posedge clk_raw) $rose(rst_n) |-> !wb_valid)
        else $error("wb_valid high in the cycle after reset release");

endmodule

bind mips_pipeline mips_pipeline_assertions u_assertions (.*);

/* test/mips_pipeline_tb.sv */
`timescale 1ns/1ps

module mips_pipeline_tb
    import mips_pkg::*;
();

    logic                       clk;
    logic                       rst_n;
    logic                       run;
    logic                       imem_we;
    logic [imem_addr_width-1:0] imem_addr;
    logic [data_width-1:0]      imem_data;
    logic                       wb_valid;
    logic [reg_addr_width-1:0]  wb_idx;
    logic [data_width-1:0]      wb_data;

    // tests as read from the data file, flattened
    logic [8*32-1:0]           test_name [$];
    int                        prog_start [$];
    int                        prog_len [$];
    logic [data_width-1:0]     prog_word [$];
    int                        exp_start [$];
    int                        exp_len [$];
    logic [reg_addr_width-1:0] exp_reg [$];
    logic [data_width-1:0]     exp_val [$];

    int limit_cycles = 0;
    int test_errors  = 0;
    int total_errors = 0;
    int tests_failed = 0;

    mips_pipeline dut (
        .clk_raw   (clk),
        .rst_n     (rst_n),
        .run       (run),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic read_tests(output bit ok);
        int                        fd;
        int                        code;
        int                        n;
        logic [8*16-1:0]           tok;
        logic [8*128-1:0]          skip;
        logic [8*32-1:0]           name;
        logic [data_width-1:0]     word;
        logic [reg_addr_width-1:0] ridx;
        ok = 1'b0;
        fd = $fopen("test/mips_pipeline_tests.txt", "r");
        if (fd != 0) begin
            tok  = '0;
            code = $fscanf(fd, "%s", tok);
            while (code == 1) begin
                if (tok == "#") begin
                    code = $fgets(skip, fd);
                end else if (tok == "test") begin
                    name = '0;
                    code = $fscanf(fd, "%s", name);
                    test_name.push_back(name);
                end else if (tok == "prog") begin
                    code = $fscanf(fd, "%d", n);
                    prog_start.push_back(prog_word.size());
                    prog_len.push_back(n);
                    repeat (n) begin
                        code = $fscanf(fd, "%h", word);
                        prog_word.push_back(word);
                    end
                end else if (tok == "wb") begin
                    code = $fscanf(fd, "%d", n);
                    exp_start.push_back(exp_reg.size());
                    exp_len.push_back(n);
                    repeat (n) begin
                        code = $fscanf(fd, "%h %h", ridx, word);
                        exp_reg.push_back(ridx);
                        exp_val.push_back(word);
                    end
                end
                tok  = '0;
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
            ok = (test_name.size() > 0) && (prog_len.size() == test_name.size())
                 && (exp_len.size() == test_name.size());
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n   = 1'b0;
        run     = 1'b0;
        imem_we = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic check_idle(input int t);
        assert (!wb_valid) else begin
            $display("%0s: write-back to register %0d while the program was loading",
                     test_name[t], wb_idx);
            test_errors++;
        end
    endtask

    task automatic load_program(input int t);
        int i;
        int gap;
        for (i = 0; i < prog_len[t]; i++) begin
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                #1;
                imem_we = 1'b0;
                check_idle(t);
            end
            @(posedge clk);
            #1;
            imem_we   = 1'b1;
            imem_addr = imem_addr_width'(i);
            imem_data = prog_word[prog_start[t] + i];
            check_idle(t);
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        run     = 1'b1;
    endtask

    // outputs are sampled on the falling edge
    task automatic check_writebacks(input int t);
        int k;
        int seen;
        k    = exp_start[t];
        seen = 0;
        while (seen < exp_len[t]) begin
            @(negedge clk);
            if (wb_valid) begin
                assert (wb_idx == exp_reg[k + seen]) else begin
                    $display("Error: %0s write-back %0d: wb_idx expected %h, got %h",
                             test_name[t], seen, exp_reg[k + seen], wb_idx);
                    test_errors++;
                end
                assert (wb_data == exp_val[k + seen]) else begin
                    $display("Error: %0s write-back %0d: wb_data expected %h, got %h",
                             test_name[t], seen, exp_val[k + seen], wb_data);
                    test_errors++;
                end
                seen++;
            end
        end
        repeat (30) begin
            @(negedge clk);
            assert (!wb_valid) else begin
                $display("%0s: unexpected write-back to register %0d after the last expected one",
                         test_name[t], wb_idx);
                test_errors++;
            end
        end
    endtask

    initial begin
        int t;
        int cycles;
        bit ok;
        rst_n     = 1'b0;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        void'($urandom(32'h93736ceb));
        read_tests(ok);
        if (!ok) begin
            $display("test file test/mips_pipeline_tests.txt is missing or malformed");
            $display("Result: FAILED");
        end else begin
            cycles = 0;
            for (t = 0; t < test_name.size(); t++) begin
                cycles += 100 * prog_len[t] + 50;
            end
            limit_cycles = cycles;
            for (t = 0; t < test_name.size(); t++) begin
                test_errors = 0;
                apply_reset();
                load_program(t);
                check_writebacks(t);
                @(posedge clk);
                #1;
                run = 1'b0;
                total_errors += test_errors;
                if (test_errors == 0) begin
                    $display("test %0d %0s: ok, %0d write-backs", t, test_name[t], exp_len[t]);
                end else begin
                    tests_failed++;
                    $display("test %0d %0s: %0d errors", t, test_name[t], test_errors);
                end
            end
            $display("%0d tests, %0d passed, %0d failed, %0d errors", test_name.size(),
                     test_name.size() - tests_failed, tests_failed, total_errors);
            if (total_errors == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
        end
        $finish;
    end

    // watchdog, armed once the tests are known
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a test did not finish", limit_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* test/mips_pipeline_tests.txt */
# test <name>, then prog <n> and n instruction words in hex,
# then wb <n> and n pairs of register index and value in hex
test arith_forwarding
prog 11
20010005 20220003 00221820 00612022 00832824 00a13025
0026382a 2008fffd 0101482a 00465022 0800000a
wb 10
01 00000005 02 00000008 03 0000000d 04 00000008 05 00000008
06 0000000d 07 00000001 08 fffffffd 09 00000001 0a fffffffb
test memory_load_use
prog 11
2001002a 20020008 ac410004 8c430004 00612020 20050007
ac050000 8c060000 8c470004 00e64022 0800000a
wb 8
01 0000002a 02 00000008 03 0000002a 04 00000054
05 00000007 06 00000007 07 0000002a 08 00000023
test branches
prog 15
20010003 20020003 10220001 20030063 14220001 20040011 20850001 14a40001
20060077 10a10001 20a70001 20080002 2108ffff 1500fffe 0800000e
wb 8
01 00000003 02 00000003 04 00000011 05 00000012
07 00000013 08 00000002 08 00000001 08 00000000
test jump
prog 7
20010001 08000004 20020022 20030033 20240040 08000005 20050055
wb 2
01 00000001 04 00000041
test register_zero
prog 5
20010009 20000012 00011020 00001825 08000004
wb 3
01 00000009 02 00000009 03 00000000

/* mips_pipeline.f */
logic/mips_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/mips_pipeline.sv
test/mips_pipeline_assertions.sv
test/mips_pipeline_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mips_pipeline_tb \
    -f mips_pipeline.f -o mips_pipeline_sim \
    && ./obj_dir/mips_pipeline_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
